/* design/counter_state_if.sv */
// Carries the counter values and counter control registers to the read path
interface counter_state_if import csr_pkg::*; ();

  csr_long_t    cycle;
  csr_long_t    instret;
  counter_ctl_t mcounteren;
  counter_ctl_t mcountinhibit;

  modport bank (output cycle, instret, mcounteren, mcountinhibit);

  modport reader (input cycle, instret, mcounteren, mcountinhibit);

endinterface

/* design/csr_access_check.sv */
// Merges a CSR operation into the next value and decides whether the access may commit
module csr_access_check import csr_pkg::*; (
  input  csr_addr_t   csr_addr,
  input  csr_op_t     csr_op,
  input  csr_word_t   new_val,
  input  logic        valid_write,
  input  priv_level_t curr_priv,
  input  csr_word_t   old_val,
  input  logic        addr_bad,
  output logic        invalid_csr,
  output csr_addr_t   wr_addr,
  output csr_word_t   wr_data,
  output logic        wr_en
);

  logic      op_active;
  logic      ro_viol;
  logic      priv_viol;
  csr_word_t merged;

  assign op_active = (csr_op != CSR_NONE);

  // New value after the read-modify-write
  always_comb begin
    case (csr_op)
      CSR_WRITE: merged = new_val;
      CSR_SET:   merged = old_val | new_val;
      CSR_CLEAR: merged = old_val & ~new_val;
      default:   merged = new_val;
    endcase
  end

  // Top address bits 11 mark the read-only space
  assign ro_viol = (csr_addr[11:10] == 2'b11) && op_active && valid_write;

  // Privilege field of the address against the current mode
  assign priv_viol = op_active && (csr_addr[9:8] > curr_priv);

  assign invalid_csr = op_active && (ro_viol || priv_viol || addr_bad);

  assign wr_addr = csr_addr;
  assign wr_data = merged;
  assign wr_en   = valid_write && op_active && !invalid_csr; // One-cycle commit

endmodule

/* design/csr_counters.sv */
// Cycle and retired-instruction counters with their enable and inhibit registers
module csr_counters import csr_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  csr_addr_t wr_addr,
  input  csr_word_t wr_data,
  input  logic      wr_en,
  input  logic      inst_ret,
  counter_state_if.bank cnt
);

  csr_long_t    cycle_q, cycle_next;
  csr_long_t    instret_q, instret_next;
  counter_ctl_t mcounteren, mcounteren_next;
  counter_ctl_t mcountinhibit, mcountinhibit_next;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycle_q       <= '0;
      instret_q     <= '0;
      mcounteren    <= '1; // User access open after reset
      mcountinhibit <= '0;
    end else begin
      cycle_q       <= cycle_next;
      instret_q     <= instret_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
    end
  end

  always_comb begin
    cycle_next         = mcountinhibit.cy ? cycle_q : cycle_q + 64'd1;
    instret_next       = mcountinhibit.ir ? instret_q : instret_q + 64'(inst_ret);
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;

    // A loaded half replaces the count for this cycle
    if (wr_en) begin
      case (wr_addr)
        MCYCLE_ADDR:     cycle_next   = {cycle_q[63:32], wr_data};
        MCYCLEH_ADDR:    cycle_next   = {wr_data, cycle_q[31:0]};
        MINSTRET_ADDR:   instret_next = {instret_q[63:32], wr_data};
        MINSTRETH_ADDR:  instret_next = {wr_data, instret_q[31:0]};
        MCOUNTEREN_ADDR: mcounteren_next = counter_ctl_t'(wr_data);
        MCOUNTINHIBIT_ADDR: begin
          mcountinhibit_next    = counter_ctl_t'(wr_data);
          mcountinhibit_next.tm = 1'b0; // Time cannot be inhibited
        end
        default: ;
      endcase
    end
  end

  assign cnt.cycle         = cycle_q;
  assign cnt.instret       = instret_q;
  assign cnt.mcounteren    = mcounteren;
  assign cnt.mcountinhibit = mcountinhibit;

endmodule

/* design/csr_file.sv */
// Top level of the machine-mode CSR file, connecting access check, registers and read path
module csr_file import csr_pkg::*; #(
  parameter csr_word_t HART_ID = '0
) (
  input  logic        CLK,
  input  logic        nRST,
  input  csr_long_t   mtime,
  input  csr_addr_t   csr_addr,
  input  csr_op_t     csr_op,
  input  csr_word_t   new_csr_val,
  input  logic        valid_write,
  input  priv_level_t curr_priv,
  input  logic        inst_ret,
  // Trap logic injection
  input  logic        inject_mstatus,
  input  mstatus_t    next_mstatus,
  input  logic        inject_mepc,
  input  csr_word_t   next_mepc,
  input  logic        inject_mcause,
  input  csr_word_t   next_mcause,
  input  logic        inject_mtval,
  input  csr_word_t   next_mtval,
  input  logic        inject_mip,
  input  mint_t       next_mip,
  output csr_word_t   old_csr_val,
  output logic        invalid_csr,
  // Current trap state for the core
  output mstatus_t    curr_mstatus,
  output mint_t       curr_mie,
  output mint_t       curr_mip,
  output mtvec_t      curr_mtvec,
  output csr_word_t   curr_mepc,
  output csr_word_t   curr_mcause
);

  csr_addr_t wr_addr;
  csr_word_t wr_data;
  logic      wr_en;
  logic      addr_bad;

  csr_state_if     state_if ();
  counter_state_if cnt_if ();

  csr_access_check u_check (
    .csr_addr    (csr_addr),
    .csr_op      (csr_op),
    .new_val     (new_csr_val),
    .valid_write (valid_write),
    .curr_priv   (curr_priv),
    .old_val     (old_csr_val),
    .addr_bad    (addr_bad),
    .invalid_csr (invalid_csr),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_en       (wr_en)
  );

  csr_trap_regs u_trap_regs (
    .CLK            (CLK),
    .nRST           (nRST),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .wr_en          (wr_en),
    .inject_mstatus (inject_mstatus),
    .next_mstatus   (next_mstatus),
    .inject_mepc    (inject_mepc),
    .next_mepc      (next_mepc),
    .inject_mcause  (inject_mcause),
    .next_mcause    (next_mcause),
    .inject_mtval   (inject_mtval),
    .next_mtval     (next_mtval),
    .inject_mip     (inject_mip),
    .next_mip       (next_mip),
    .state          (state_if.bank)
  );

  csr_counters u_counters (
    .CLK      (CLK),
    .nRST     (nRST),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_en    (wr_en),
    .inst_ret (inst_ret),
    .cnt      (cnt_if.bank)
  );

  csr_read_mux #(.HART_ID(HART_ID)) u_read_mux (
    .csr_addr  (csr_addr),
    .curr_priv (curr_priv),
    .mtime     (mtime),
    .state     (state_if.reader),
    .cnt       (cnt_if.reader),
    .old_val   (old_csr_val),
    .addr_bad  (addr_bad)
  );

  assign curr_mstatus = state_if.mstatus;
  assign curr_mie     = state_if.mie;
  assign curr_mip     = state_if.mip;
  assign curr_mtvec   = state_if.mtvec;
  assign curr_mepc    = state_if.mepc;
  assign curr_mcause  = state_if.mcause;

endmodule

/* design/csr_pkg.sv */
// Shared widths, enums, register layouts and reset constants for the machine-mode CSR file
package csr_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0]   csr_word_t;
  typedef logic [2*XLEN-1:0] csr_long_t;

  // Only user and machine mode exist on this core
  typedef enum logic [1:0] {
    U_MODE = 2'd0,
    M_MODE = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_WRITE,
    CSR_SET,
    CSR_CLEAR
  } csr_op_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } tvec_mode_t;

  typedef enum logic [11:0] {
    // Machine information, read only
    MVENDORID_ADDR     = 12'hF11,
    MARCHID_ADDR       = 12'hF12,
    MIMPID_ADDR        = 12'hF13,
    MHARTID_ADDR       = 12'hF14,
    MCONFIGPTR_ADDR    = 12'hF15,
    // Machine trap setup
    MSTATUS_ADDR       = 12'h300,
    MISA_ADDR          = 12'h301,
    MIE_ADDR           = 12'h304,
    MTVEC_ADDR         = 12'h305,
    MCOUNTEREN_ADDR    = 12'h306,
    MCOUNTINHIBIT_ADDR = 12'h320,
    // Machine trap handling
    MSCRATCH_ADDR      = 12'h340,
    MEPC_ADDR          = 12'h341,
    MCAUSE_ADDR        = 12'h342,
    MTVAL_ADDR         = 12'h343,
    MIP_ADDR           = 12'h344,
    // Machine counters
    MCYCLE_ADDR        = 12'hB00,
    MINSTRET_ADDR      = 12'hB02,
    MCYCLEH_ADDR       = 12'hB80,
    MINSTRETH_ADDR     = 12'hB82,
    // User read-only shadows
    CYCLE_ADDR         = 12'hC00,
    TIME_ADDR          = 12'hC01,
    INSTRET_ADDR       = 12'hC02,
    CYCLEH_ADDR        = 12'hC80,
    TIMEH_ADDR         = 12'hC81,
    INSTRETH_ADDR      = 12'hC82
  } csr_addr_t;

  typedef struct packed {
    logic [9:0]  rsvd_31_22;
    logic        tw;          // Timeout wait
    logic [2:0]  rsvd_20_18;
    logic        mprv;        // Modify privilege
    logic [3:0]  rsvd_16_13;
    priv_level_t mpp;         // Previous privilege
    logic [2:0]  rsvd_10_8;
    logic        mpie;
    logic [2:0]  rsvd_6_4;
    logic        mie;         // Global machine interrupt enable
    logic [2:0]  rsvd_2_0;
  } mstatus_t;

  typedef struct packed {
    logic [29:0] base;
    tvec_mode_t  mode;
  } mtvec_t;

  // Same layout for mie and mip
  typedef struct packed {
    logic [19:0] rsvd_31_12;
    logic        mei;
    logic [2:0]  rsvd_10_8;
    logic        mti;
    logic [2:0]  rsvd_6_4;
    logic        msi;
    logic [2:0]  rsvd_2_0;
  } mint_t;

  // Same layout for mcounteren and mcountinhibit
  typedef struct packed {
    logic [28:0] hpm;   // No hpm counters behind these bits
    logic        ir;
    logic        tm;
    logic        cy;
  } counter_ctl_t;

  // MXL of 1 for RV32, with I and U
  localparam csr_word_t MISA_VALUE = 32'h4010_0100;

  localparam mstatus_t MSTATUS_RESET = '{tw: 1'b1, mpp: U_MODE, default: '0};

endpackage

/* design/csr_read_mux.sv */
// Selects the CSR read value by address and flags unknown or gated addresses
module csr_read_mux import csr_pkg::*; #(
  parameter csr_word_t HART_ID = '0
) (
  input  csr_addr_t   csr_addr,
  input  priv_level_t curr_priv,
  input  csr_long_t   mtime,
  csr_state_if.reader     state,
  counter_state_if.reader cnt,
  output csr_word_t   old_val,
  output logic        addr_bad
);

  logic user_mode;
  logic cy_blocked;
  logic tm_blocked;
  logic ir_blocked;

  assign user_mode  = (curr_priv == U_MODE);
  assign cy_blocked = user_mode && !cnt.mcounteren.cy;
  assign tm_blocked = user_mode && !cnt.mcounteren.tm;
  assign ir_blocked = user_mode && !cnt.mcounteren.ir;

  always_comb begin
    old_val  = '0;
    addr_bad = 1'b0;
    case (csr_addr)
      // Fixed information
      MVENDORID_ADDR,
      MARCHID_ADDR,
      MIMPID_ADDR,
      MCONFIGPTR_ADDR:    old_val = '0;
      MHARTID_ADDR:       old_val = HART_ID;
      MISA_ADDR:          old_val = MISA_VALUE;
      // Trap registers
      MSTATUS_ADDR:       old_val = state.mstatus;
      MTVEC_ADDR:         old_val = state.mtvec;
      MIE_ADDR:           old_val = state.mie;
      MIP_ADDR:           old_val = state.mip;
      MSCRATCH_ADDR:      old_val = state.mscratch;
      MEPC_ADDR:          old_val = state.mepc;
      MCAUSE_ADDR:        old_val = state.mcause;
      MTVAL_ADDR:         old_val = state.mtval;
      // Counter control
      MCOUNTEREN_ADDR:    old_val = cnt.mcounteren;
      MCOUNTINHIBIT_ADDR: old_val = cnt.mcountinhibit;
      MCYCLE_ADDR:        old_val = cnt.cycle[31:0];
      MCYCLEH_ADDR:       old_val = cnt.cycle[63:32];
      MINSTRET_ADDR:      old_val = cnt.instret[31:0];
      MINSTRETH_ADDR:     old_val = cnt.instret[63:32];
      // User shadows, gated by mcounteren in user mode
      CYCLE_ADDR: begin
        addr_bad = cy_blocked;
        old_val  = cy_blocked ? '0 : cnt.cycle[31:0];
      end
      CYCLEH_ADDR: begin
        addr_bad = cy_blocked;
        old_val  = cy_blocked ? '0 : cnt.cycle[63:32];
      end
      TIME_ADDR: begin
        addr_bad = tm_blocked;
        old_val  = tm_blocked ? '0 : mtime[31:0];
      end
      TIMEH_ADDR: begin
        addr_bad = tm_blocked;
        old_val  = tm_blocked ? '0 : mtime[63:32];
      end
      INSTRET_ADDR: begin
        addr_bad = ir_blocked;
        old_val  = ir_blocked ? '0 : cnt.instret[31:0];
      end
      INSTRETH_ADDR: begin
        addr_bad = ir_blocked;
        old_val  = ir_blocked ? '0 : cnt.instret[63:32];
      end
      default: addr_bad = 1'b1; // Not implemented here
    endcase
  end

endmodule

/* design/csr_state_if.sv */
// Carries the machine trap register values from the register bank to the read path
interface csr_state_if import csr_pkg::*; ();

  mstatus_t  mstatus;
  mtvec_t    mtvec;
  mint_t     mie;
  mint_t     mip;
  csr_word_t mscratch;
  csr_word_t mepc;
  csr_word_t mcause;
  csr_word_t mtval;

  modport bank (
    output mstatus, mtvec, mie, mip,
    output mscratch, mepc, mcause, mtval
  );

  modport reader (
    input mstatus, mtvec, mie, mip,
    input mscratch, mepc, mcause, mtval
  );

endinterface

/* design/csr_trap_regs.sv */
// Machine trap registers with legal-value rules, software writes and trap-logic injection
module csr_trap_regs import csr_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  csr_addr_t wr_addr,
  input  csr_word_t wr_data,
  input  logic      wr_en,
  input  logic      inject_mstatus,
  input  mstatus_t  next_mstatus,
  input  logic      inject_mepc,
  input  csr_word_t next_mepc,
  input  logic      inject_mcause,
  input  csr_word_t next_mcause,
  input  logic      inject_mtval,
  input  csr_word_t next_mtval,
  input  logic      inject_mip,
  input  mint_t     next_mip,
  csr_state_if.bank state
);

  mstatus_t  mstatus, mstatus_next;
  mtvec_t    mtvec, mtvec_next;
  mint_t     mie, mie_next;
  mint_t     mip, mip_next;
  csr_word_t mscratch, mscratch_next;
  csr_word_t mepc, mepc_next;
  csr_word_t mcause, mcause_next;
  csr_word_t mtval, mtval_next;

  // Keeps only the implemented mstatus fields
  function automatic mstatus_t legal_mstatus(csr_word_t val);
    mstatus_t r;
    r = '0;
    r.mie  = val[3];
    r.mpie = val[7];
    r.mpp  = (val[12:11] == M_MODE) ? M_MODE : U_MODE; // Unsupported modes fall to user
    r.mprv = val[17];
    r.tw   = val[21];
    return r;
  endfunction

  function automatic mint_t legal_mint(csr_word_t val);
    mint_t r;
    r = '0;
    r.msi = val[3];
    r.mti = val[7];
    r.mei = val[11];
    return r;
  endfunction

  function automatic mtvec_t legal_mtvec(csr_word_t val);
    mtvec_t r;
    r.base = val[31:2];
    r.mode = (val[1:0] == 2'b01) ? VECTORED : DIRECT; // Reserved modes read as direct
    return r;
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus  <= MSTATUS_RESET;
      mtvec    <= '0;
      mie      <= '0;
      mip      <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else begin
      mstatus  <= mstatus_next;
      mtvec    <= mtvec_next;
      mie      <= mie_next;
      mip      <= mip_next;
      mscratch <= mscratch_next;
      mepc     <= mepc_next;
      mcause   <= mcause_next;
      mtval    <= mtval_next;
    end
  end

  always_comb begin
    mstatus_next  = mstatus;
    mtvec_next    = mtvec;
    mie_next      = mie;
    mip_next      = mip;
    mscratch_next = mscratch;
    mepc_next     = mepc;
    mcause_next   = mcause;
    mtval_next    = mtval;

    // Software access
    if (wr_en) begin
      case (wr_addr)
        MSTATUS_ADDR:  mstatus_next  = legal_mstatus(wr_data);
        MTVEC_ADDR:    mtvec_next    = legal_mtvec(wr_data);
        MIE_ADDR:      mie_next      = legal_mint(wr_data);
        MIP_ADDR:      mip_next      = legal_mint(wr_data);
        MSCRATCH_ADDR: mscratch_next = wr_data;
        MEPC_ADDR:     mepc_next     = wr_data;
        MCAUSE_ADDR:   mcause_next   = wr_data;
        MTVAL_ADDR:    mtval_next    = wr_data;
        default: ;
      endcase
    end

    // Trap logic has the last word
    if (inject_mstatus) mstatus_next = legal_mstatus(next_mstatus);
    if (inject_mepc)    mepc_next    = next_mepc;
    if (inject_mcause)  mcause_next  = next_mcause;
    if (inject_mtval)   mtval_next   = next_mtval;
    if (inject_mip)     mip_next     = legal_mint(next_mip);
  end

  assign state.mstatus  = mstatus;
  assign state.mtvec    = mtvec;
  assign state.mie      = mie;
  assign state.mip      = mip;
  assign state.mscratch = mscratch;
  assign state.mepc     = mepc;
  assign state.mcause   = mcause;
  assign state.mtval    = mtval;

endmodule

/* list.f */
design/csr_pkg.sv
design/csr_state_if.sv
design/counter_state_if.sv
design/csr_access_check.sv
design/csr_trap_regs.sv
design/csr_counters.sv
design/csr_read_mux.sv
design/csr_file.sv
tests/csr_file_tb.sv

/* tests/csr_file_tb.sv */
// Self-checking testbench for the CSR file, run line by line from tests/csr_testdata.txt
module csr_file_tb import csr_pkg::*; ();

  localparam csr_word_t HART_NUM    = 32'h0000_0005;
  localparam int        COLS        = 9;  // Words per data line
  localparam int        MAX_LINES   = 64;
  localparam int        INJECT_WAIT = 4;  // Edges allowed for an injection to land

  logic [63:0] vec [0:COLS*MAX_LINES-1];

  logic        CLK;
  logic        nRST;
  csr_long_t   mtime;
  csr_addr_t   csr_addr;
  csr_op_t     csr_op;
  csr_word_t   new_csr_val;
  logic        valid_write;
  priv_level_t curr_priv;
  logic        inst_ret;
  logic        inject_mstatus, inject_mepc, inject_mcause, inject_mtval, inject_mip;
  mstatus_t    next_mstatus;
  csr_word_t   next_mepc, next_mcause, next_mtval;
  mint_t       next_mip;
  csr_word_t   old_csr_val;
  logic        invalid_csr;
  mstatus_t    curr_mstatus;
  mint_t       curr_mie, curr_mip;
  mtvec_t      curr_mtvec;
  csr_word_t   curr_mepc, curr_mcause;

  int errors, line_errors, tests, failed_tests;

  csr_file #(.HART_ID(HART_NUM)) dut0 (.*);

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s expected %h got %h", $time, name, exp, got);
      errors++;
      line_errors++;
    end
  endtask

  task automatic drive_idle();
    csr_op         = CSR_NONE;
    valid_write    = 1'b0;
    new_csr_val    = '0;
    inject_mstatus = 1'b0;
    inject_mepc    = 1'b0;
    inject_mcause  = 1'b0;
    inject_mtval   = 1'b0;
    inject_mip     = 1'b0;
    next_mstatus   = '0;
    next_mepc      = '0;
    next_mcause    = '0;
    next_mtval     = '0;
    next_mip       = '0;
  endtask

  // Trap register value the core sees for an injection target
  function automatic csr_word_t curr_trap_value(input csr_addr_t a);
    case (a)
      MEPC_ADDR:   return curr_mepc;
      MCAUSE_ADDR: return curr_mcause;
      MIP_ADDR:    return curr_mip;
      default:     return curr_mstatus;
    endcase
  endfunction

  // One CSR access, held for one cycle and checked just before the next edge
  task automatic run_access(input int b);
    @(posedge CLK);
    #2;
    csr_op      = csr_op_t'(vec[b+1][1:0]);
    csr_addr    = csr_addr_t'(vec[b+2][11:0]);
    curr_priv   = priv_level_t'(vec[b+3][1:0]);
    new_csr_val = vec[b+4][31:0];
    valid_write = vec[b+5][0];
    mtime       = vec[b+6];
    #16;
    if (vec[b] != 64'h2) begin
      check_value("old_csr_val", old_csr_val, vec[b+7]);
      // Core-side copy of a trap register matches its readback
      case (csr_addr)
        MSTATUS_ADDR: check_value("curr_mstatus", curr_mstatus, vec[b+7]);
        MIE_ADDR:     check_value("curr_mie", curr_mie, vec[b+7]);
        MTVEC_ADDR:   check_value("curr_mtvec", curr_mtvec, vec[b+7]);
        MEPC_ADDR:    check_value("curr_mepc", curr_mepc, vec[b+7]);
        MCAUSE_ADDR:  check_value("curr_mcause", curr_mcause, vec[b+7]);
        MIP_ADDR:     check_value("curr_mip", curr_mip, vec[b+7]);
        default: ;
      endcase
    end
    check_value("invalid_csr", invalid_csr, vec[b+8]);
  endtask

  // Injection, optionally racing a software access, then a readback in M_MODE
  task automatic run_inject(input int b);
    csr_addr_t target;
    int        waited;
    target = csr_addr_t'(vec[b+2][11:0]);
    @(posedge CLK);
    #2;
    csr_addr      = target;
    csr_op        = csr_op_t'(vec[b+1][1:0]);
    curr_priv     = priv_level_t'(vec[b+3][1:0]);
    valid_write   = vec[b+5][0];
    mtime         = vec[b+6];
    new_csr_val   = vec[b+6][31:0]; // Software data rides in the mtime column
    inject_mepc   = (target == MEPC_ADDR);
    inject_mcause = (target == MCAUSE_ADDR);
    inject_mip    = (target == MIP_ADDR);
    next_mepc     = vec[b+4][31:0];
    next_mcause   = vec[b+4][31:0];
    next_mip      = mint_t'(vec[b+4][31:0]);
    waited = 0;
    do begin
      @(posedge CLK);
      #1;
      waited++;
    end while (curr_trap_value(target) !== vec[b+7][31:0] && waited < INJECT_WAIT);
    if (curr_trap_value(target) !== vec[b+7][31:0]) begin
      $display("Injected value never reached the core outputs at time %0t", $time);
      errors++;
      line_errors++;
    end else if (waited != 1) begin
      $display("Injection took %0d cycles to reach the core outputs", waited);
      errors++;
      line_errors++;
    end
    #1;
    drive_idle();
    curr_priv = M_MODE;
    #16;
    check_value("old_csr_val", old_csr_val, vec[b+7]);
    check_value("invalid_csr", invalid_csr, vec[b+8]);
  endtask

  initial begin
    int   n;
    int   base;
    logic found_end;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    found_end    = 1'b0;
    nRST         = 1'b0;
    mtime        = '0;
    csr_addr     = MSTATUS_ADDR;
    curr_priv    = M_MODE;
    inst_ret     = 1'b0;   // instret stays still, so its halves read exactly
    drive_idle();
    $readmemh("tests/csr_testdata.txt", vec);
    repeat (10) @(posedge CLK);
    #2 nRST = 1'b1;

    for (n = 0; n < MAX_LINES; n++) begin
      base = n * COLS;
      if (vec[base] === 64'hF) begin
        found_end = 1'b1;
        break;
      end
      if (vec[base] !== 64'h0 && vec[base] !== 64'h1 && vec[base] !== 64'h2)
        break;
      line_errors = 0;
      if (vec[base] == 64'h1)
        run_inject(base);
      else
        run_access(base);
      tests++;
      if (line_errors != 0)
        failed_tests++;
      $display("Test %0d %s addr %h: %s", n, (vec[base] == 64'h1) ? "inject" : "access",
               vec[base+2][11:0], (line_errors == 0) ? "ok" : "failed");
    end
    drive_idle();

    if (!found_end || tests == 0) begin
      $display("Test data is missing, unreadable or has no end marker");
      errors++;
    end
    $display("Tests run %0d, failed %0d, mismatches %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* tests/csr_testdata.txt */
// kind op addr priv value valid_write mtime exp_old_csr_val exp_invalid_csr, all hex
// kind 0 access, 2 access without old value check, 1 inject (sw data in mtime), F end
0 0 300 3 00000000 0 0000000000000000 00200000 0
0 0 306 3 00000000 0 0000000000000000 FFFFFFFF 0
0 0 F14 3 00000000 0 0000000000000000 00000005 0
0 0 301 3 00000000 0 0000000000000000 40100100 0
0 0 F11 3 00000000 0 0000000000000000 00000000 0
0 1 340 3 A5A5F00F 1 0000000000000000 00000000 0
0 2 340 3 00000FF0 1 0000000000000000 A5A5F00F 0
0 3 340 3 A5000000 1 0000000000000000 A5A5FFFF 0
0 0 340 3 00000000 0 0000000000000000 00A5FFFF 0
0 1 304 3 FFFFFFFF 1 0000000000000000 00000000 0
0 3 304 3 00000080 1 0000000000000000 00000888 0
0 2 304 3 00000001 1 0000000000000000 00000808 0
0 0 304 3 00000000 0 0000000000000000 00000808 0
0 1 300 3 00001009 1 0000000000000000 00200000 0
0 0 300 3 00000000 0 0000000000000000 00000008 0
0 1 305 3 80000103 1 0000000000000000 00000000 0
0 0 305 3 00000000 0 0000000000000000 80000100 0
0 1 F11 3 12345678 1 0000000000000000 00000000 1
0 1 341 0 DEADBEEF 1 0000000000000000 00000000 1
0 0 341 3 00000000 0 0000000000000000 00000000 0
0 1 7C0 3 11111111 1 0000000000000000 00000000 1
0 3 123 3 11111111 1 0000000000000000 00000000 1
0 2 320 3 00000005 1 0000000000000000 00000000 0
0 1 B80 3 0000ABCD 1 0000000000000000 00000000 0
2 1 B00 3 00001234 1 0000000000000000 00000000 0
0 1 B82 3 00C0FFEE 1 0000000000000000 00000000 0
0 0 B00 3 00000000 0 0000000000000000 00001234 0
0 0 B80 3 00000000 0 0000000000000000 0000ABCD 0
0 0 B82 3 00000000 0 0000000000000000 00C0FFEE 0
0 2 C00 3 00000000 0 0000000000000000 00001234 0
0 3 306 3 00000001 1 0000000000000000 FFFFFFFF 0
0 2 C00 0 00000000 0 0000000000000000 00000000 1
0 2 C01 3 00000000 0 0123456789ABCDEF 89ABCDEF 0
0 2 C81 3 00000000 0 0123456789ABCDEF 01234567 0
1 0 341 3 80000040 0 0000000000000000 80000040 0
1 0 342 3 8000000B 0 0000000000000000 8000000B 0
1 0 344 3 FFFFFFFF 0 0000000000000000 00000888 0
1 1 341 3 00000100 1 0000000012345678 00000100 0
F 0 000 0 00000000 0 0000000000000000 00000000 0
